/* font.mem */
// one glyph per line, hex digits 0 to F, 8 rows of 8 bits, row 0 in the top byte
3C666E7666663C00
1838181818187E00
3C66060C30607E00
3C66061C06663C00
0C1C2C4C7E0C0C00
7E607C0606663C00
3C60607C66663C00
7E060C1818181800
3C66663C66663C00
3C66663E06063C00
183C66667E666600
7C66667C66667C00
3C66606060663C00
786C6666666C7800
7E60607860607E00
7E60607860606000

/* flist.f */
+incdir+include
logic/osd_pkg.sv
logic/spi_ram_slave.sv
logic/osd_store.sv
logic/video_timing.sv
logic/font_rom.sv
logic/osd_overlay.sv
logic/osd_top.sv
bench/osd_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the OSD testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -f flist.f --top-module osd_tb \
  --Mdir "$BUILD_DIR" -o osd_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/osd_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* bench/osd_tb.sv */
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_tb
  import osd_pkg::*;
();

  localparam int FRAME_CYC   = `OSD_H_TOTAL * `OSD_V_TOTAL;
  localparam int TIMEOUT_CYC = 12 * FRAME_CYC;
  localparam int WIN_W       = `OSD_CHARS_X * `OSD_GLYPH_PX;
  localparam int WIN_H       = `OSD_CHARS_Y * `OSD_GLYPH_PX;

  logic                  clk_cpu;
  logic                  i_rst_n;
  logic                  i_csn;
  logic                  i_sclk;
  logic                  i_mosi;
  logic [`OSD_BTN_W-1:0] i_btn;
  logic                  o_miso;
  logic                  o_irq;
  video_t                o_video;

  logic [63:0] font_m [0:15];  // local copy of the glyphs
  logic [7:0]  shadow [0:31];  // characters as written
  logic [7:0]  tx_buf [0:31];
  logic [7:0]  rx_buf [0:31];
  logic [15:0] lfsr_state;
  logic        osd_on_m;
  logic        chk_vid;
  logic        chk_pix;
  logic        idle_chk;
  logic        rst_seen;
  int          err_cnt;
  int          err_mark;
  int          pass_cnt;
  int          fail_cnt;
  int          test_no;
  int          cycle_cnt;
  int          hs_len;
  int          hs_gap;
  int          hs_rises;
  int          vs_len;
  int          vs_pulses;
  logic        prev_hs;
  logic        prev_vs;

  osd_top u_dut (
    .clk_cpu (clk_cpu),
    .i_rst_n (i_rst_n),
    .i_csn   (i_csn),
    .i_sclk  (i_sclk),
    .i_mosi  (i_mosi),
    .i_btn   (i_btn),
    .o_miso  (o_miso),
    .o_irq   (o_irq),
    .o_video (o_video)
  );

  initial
  begin
    clk_cpu = 1'b0;
    forever #20 clk_cpu = ~clk_cpu;
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++)
      b = {b[6:0], lfsr_bit()};
    return b;
  endfunction

  // expected colors of an active pixel
  function automatic logic [23:0] pixel_model(input int x, input int y);
    logic [7:0] code;
    logic [7:0] row_bits;
    logic       on;
    int         wx;
    int         wy;
    wx = x - `OSD_WIN_X;
    wy = y - `OSD_WIN_Y;
    if (osd_on_m && wx >= 0 && wx < WIN_W && wy >= 0 && wy < WIN_H)
    begin
      code     = shadow[(wy / 8) * `OSD_CHARS_X + wx / 8];
      row_bits = font_m[code[3:0]][63 - 8 * (wy % 8) -: 8];
      on       = row_bits[7 - wx % 8] ^ code[7];
      if (on)
        return 24'hFFFFFF;
      return {8'(x) >> 1, 8'(y) >> 1, 8'h40};
    end
    return {8'(x), 8'(y), 8'h80};
  endfunction

  always @(posedge clk_cpu)
  begin
    logic [23:0] exp_rgb;
    if (rst_seen && idle_chk)
      assert (!o_irq && !o_miso) else report_mismatch("irq or miso set in or after reset");
    if (!i_rst_n)
      rst_seen = 1'b1;
    if (chk_vid)
    begin
      assert (o_video.blank == !(o_video.x < 8'd160 && o_video.y < 7'd120))
        else report_mismatch($sformatf("blank wrong at x %0d y %0d", o_video.x, o_video.y));
      assert (o_video.hsync == (o_video.x >= 8'd168 && o_video.x < 8'd184) &&
              o_video.vsync == (o_video.y >= 7'd122 && o_video.y < 7'd124))
        else report_mismatch($sformatf("sync wrong at x %0d y %0d", o_video.x, o_video.y));
      if (o_video.hsync && !prev_hs)
      begin
        if (hs_rises > 0)
          assert (hs_gap == `OSD_H_TOTAL) else report_mismatch($sformatf("hsync period %0d", hs_gap));
        hs_rises++;
        hs_gap = 0;
      end
      if (!o_video.hsync && prev_hs)
        assert (hs_len == `OSD_H_SYNC) else report_mismatch($sformatf("hsync width %0d", hs_len));
      if (!o_video.vsync && prev_vs)
      begin
        assert (vs_len == `OSD_V_SYNC * `OSD_H_TOTAL)
          else report_mismatch($sformatf("vsync width %0d", vs_len));
        vs_pulses++;
      end
      hs_len  = o_video.hsync ? hs_len + 1 : 0;
      vs_len  = o_video.vsync ? vs_len + 1 : 0;
      hs_gap  = hs_gap + 1;
      prev_hs = o_video.hsync;
      prev_vs = o_video.vsync;
    end
    if (chk_pix)
    begin
      exp_rgb = o_video.blank ? 24'h000000 : pixel_model(int'(o_video.x), int'(o_video.y));
      assert ({o_video.r, o_video.g, o_video.b} == exp_rgb)
        else report_mismatch($sformatf("pixel x %0d y %0d is %h expected %h", o_video.x,
                                       o_video.y, {o_video.r, o_video.g, o_video.b}, exp_rgb));
    end
  end

  // mosi set while sclk low and miso taken just before the rise
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--)
    begin
      i_sclk <= 1'b0;
      i_mosi <= tx[i];
      repeat (5) @(posedge clk_cpu);
      rx[i] = o_miso;
      i_sclk <= 1'b1;
      repeat (5) @(posedge clk_cpu);
    end
  endtask

  task automatic spi_frame(input logic [7:0] op, input logic [31:0] addr, input int n);
    logic [7:0] rx;
    i_csn <= 1'b0;
    repeat (4) @(posedge clk_cpu);
    spi_byte(op, rx);
    for (int k = 3; k >= 0; k--)
      spi_byte(addr[8 * k +: 8], rx);
    if (op == 8'h01)
      spi_byte(8'h00, rx); // dummy
    for (int k = 0; k < n; k++)
    begin
      spi_byte((op == 8'h01) ? 8'h00 : tx_buf[k], rx);
      rx_buf[k] = rx;
    end
    i_sclk <= 1'b0;
    repeat (5) @(posedge clk_cpu);
    i_csn <= 1'b1;
    repeat (10) @(posedge clk_cpu);
  endtask

  task automatic check_readback();
    spi_frame(8'h01, 32'h0000_0000, 32);
    for (int k = 0; k < 32; k++)
      assert (rx_buf[k] == shadow[k])
        else report_mismatch($sformatf("char %0d read %h expected %h", k, rx_buf[k], shadow[k]));
  endtask

  // checks every pixel of the next full frame
  task automatic check_frame();
    while (!(o_video.x == 8'(`OSD_H_TOTAL - 1) && o_video.y == 7'(`OSD_V_TOTAL - 1)))
      @(posedge clk_cpu);
    chk_pix <= 1'b1;
    repeat (FRAME_CYC) @(posedge clk_cpu);
    chk_pix <= 1'b0;
  endtask

  task automatic end_test(input string name);
    test_no++;
    if (err_cnt == err_mark)
    begin
      pass_cnt++;
      $display("test %0d %s: ok", test_no, name);
    end
    else
    begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", test_no, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  initial
  begin
    logic [`OSD_BTN_W-1:0] btn_new;
    logic [7:0]            btn_rand;
    i_rst_n <= 1'b0;
    i_csn   <= 1'b1;
    i_sclk  <= 1'b0;
    i_mosi  <= 1'b0;
    i_btn   <= '0;
    lfsr_state = 16'h0001;
    osd_on_m   = 1'b1;
    chk_vid    = 1'b0;
    chk_pix    = 1'b0;
    idle_chk   = 1'b1;
    rst_seen   = 1'b0;
    {err_cnt, err_mark, pass_cnt, fail_cnt, test_no} = '0;
    {hs_len, hs_gap, hs_rises, vs_len, vs_pulses} = '0;
    prev_hs = 1'b0;
    prev_vs = 1'b0;
    $readmemh("font.mem", font_m);
    repeat (8) @(posedge clk_cpu);
    i_rst_n <= 1'b1;
    repeat (4) @(posedge clk_cpu);
    chk_vid <= 1'b1;

    repeat (FRAME_CYC + 400) @(posedge clk_cpu);
    assert (vs_pulses >= 1 && hs_rises > 100) else report_mismatch("no sync pulses seen");
    idle_chk <= 1'b0;
    end_test("reset and video timing");

    for (int k = 0; k < 32; k++)
      tx_buf[k] = rand_byte();
    tx_buf[0][7] = 1'b1; // at least one inverse code
    tx_buf[1][7] = 1'b0;
    for (int k = 0; k < 32; k++)
      shadow[k] = tx_buf[k];
    spi_frame(8'h00, 32'h0000_0000, 32);
    check_readback();
    spi_frame(8'h01, 32'hFD00_0000, 1);
    assert (rx_buf[0] == 8'(`OSD_INIT_ON)) else report_mismatch("control register reset value");
    end_test("char ram write and read-back");

    check_frame();
    end_test("overlay drawing");

    tx_buf[0] = 8'h00;
    spi_frame(8'h00, 32'hFD00_0000, 1);
    osd_on_m = 1'b0;
    check_frame();
    tx_buf[0] = 8'h01;
    spi_frame(8'h00, 32'hFD00_0000, 1);
    osd_on_m = 1'b1;
    check_frame();
    end_test("osd disable and enable");

    btn_rand   = rand_byte();
    btn_new    = btn_rand[`OSD_BTN_W-1:0];
    btn_new[0] = 1'b1;
    @(posedge clk_cpu);
    i_btn <= btn_new;
    begin
      int wait_cyc;
      wait_cyc = 0;
      while (!o_irq && wait_cyc < 6)
      begin
        @(posedge clk_cpu);
        wait_cyc++;
      end
      assert (o_irq && wait_cyc <= 3) else report_mismatch("irq late after button change");
    end
    spi_frame(8'h01, 32'hFB00_0000, 1);
    assert (rx_buf[0] == {1'b0, btn_new})
      else report_mismatch($sformatf("button read %h expected %h", rx_buf[0], btn_new));
    repeat (50)
    begin
      @(posedge clk_cpu);
      assert (!o_irq) else report_mismatch("irq still set after button read");
    end
    end_test("button interrupt");

    tx_buf[0] = ~shadow[0];
    spi_frame(8'h00, 32'h0100_0000, 1);
    check_readback();
    end_test("unmapped write");

    $display("tests: %0d ok, %0d with errors, %0d mismatches", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYC)
    begin
      @(posedge clk_cpu);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("test failed");
    $finish;
  end

endmodule

/* logic/osd_top.sv */
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_top
  import osd_pkg::*;
(
  input  logic                  clk_cpu,
  input  logic                  i_rst_n,
  input  logic                  i_csn,
  input  logic                  i_sclk,
  input  logic                  i_mosi,
  input  logic [`OSD_BTN_W-1:0] i_btn,
  output logic                  o_miso,
  output logic                  o_irq,
  output video_t                o_video
);

  bus_req_t                req;
  logic [7:0]              rd_data;
  logic [7:0]              char_code;
  logic                    osd_en;
  logic [`OSD_CHAR_AW-1:0] char_addr;
  logic [3:0]              glyph;
  logic [2:0]              glyph_row;
  logic [7:0]              glyph_bits;
  video_t                  tim_video;

  spi_ram_slave u_spi (
    .clk_cpu   (clk_cpu),
    .i_rst_n   (i_rst_n),
    .i_csn     (i_csn),
    .i_sclk    (i_sclk),
    .i_mosi    (i_mosi),
    .i_btn     (i_btn),
    .i_rd_data (rd_data),
    .o_miso    (o_miso),
    .o_irq     (o_irq),
    .o_req     (req)
  );

  osd_store u_store (
    .clk_cpu     (clk_cpu),
    .i_rst_n     (i_rst_n),
    .i_req       (req),
    .i_char_addr (char_addr),
    .o_rd_data   (rd_data),
    .o_char      (char_code),
    .o_osd_en    (osd_en)
  );

  video_timing u_timing (
    .clk_cpu (clk_cpu),
    .i_rst_n (i_rst_n),
    .o_video (tim_video)
  );

  font_rom u_font (
    .clk_cpu (clk_cpu),
    .i_glyph (glyph),
    .i_row   (glyph_row),
    .o_bits  (glyph_bits)
  );

  osd_overlay u_overlay (
    .clk_cpu     (clk_cpu),
    .i_rst_n     (i_rst_n),
    .i_video     (tim_video),
    .i_char      (char_code),
    .i_osd_en    (osd_en),
    .i_bits      (glyph_bits),
    .o_char_addr (char_addr),
    .o_glyph     (glyph),
    .o_row       (glyph_row),
    .o_video     (o_video)
  );

endmodule

/* logic/osd_overlay.sv */
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_overlay
  import osd_pkg::*;
(
  input  logic                    clk_cpu,
  input  logic                    i_rst_n,
  input  video_t                  i_video,
  input  logic [7:0]              i_char,
  input  logic                    i_osd_en,
  input  logic [7:0]              i_bits,
  output logic [`OSD_CHAR_AW-1:0] o_char_addr,
  output logic [3:0]              o_glyph,
  output logic [2:0]              o_row,
  output video_t                  o_video
);

  localparam int GW    = $clog2(`OSD_GLYPH_PX);
  localparam int CW    = $clog2(`OSD_CHARS_X);
  localparam int RW    = $clog2(`OSD_CHARS_Y);
  localparam int WIN_W = `OSD_CHARS_X * `OSD_GLYPH_PX;
  localparam int WIN_H = `OSD_CHARS_Y * `OSD_GLYPH_PX;

  logic [7:0]    wx;
  logic [6:0]    wy;
  logic          hit;
  video_t        r_v1;
  video_t        r_v2;
  logic          r_hit1;
  logic          r_hit2;
  logic [GW-1:0] r_prow1;
  logic [GW-1:0] r_pcol1;
  logic [GW-1:0] r_pcol2;
  logic          r_inv2;
  logic          pix_on;

  // stage 0, window hit and character address
  assign wx  = i_video.x - 8'(`OSD_WIN_X);
  assign wy  = i_video.y - 7'(`OSD_WIN_Y);
  assign hit = (i_video.x >= `OSD_WIN_X) && (i_video.x < `OSD_WIN_X + WIN_W) &&
               (i_video.y >= `OSD_WIN_Y) && (i_video.y < `OSD_WIN_Y + WIN_H);
  assign o_char_addr = {wy[GW +: RW], wx[GW +: CW]}; // row * 8 + column

  // stage 1, character back from the store
  assign o_glyph = i_char[3:0];
  assign o_row   = r_prow1;

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      r_v1   <= '{blank: 1'b1, default: '0};
      r_v2   <= '{blank: 1'b1, default: '0};
      r_hit1 <= 1'b0;
      r_hit2 <= 1'b0;
    end
    else
    begin
      r_v1   <= i_video;
      r_v2   <= r_v1;
      r_hit1 <= hit;
      r_hit2 <= r_hit1;
    end
  end

  always_ff @(posedge clk_cpu)
  begin
    r_prow1 <= wy[GW-1:0];
    r_pcol1 <= wx[GW-1:0];
    r_pcol2 <= r_pcol1;
    r_inv2  <= i_char[7]; // inverse video flag
  end

  // stage 2, glyph bit and mixing, column 0 is the msb
  assign pix_on = i_bits[~r_pcol2] ^ r_inv2;

  always_comb
  begin
    o_video = r_v2;
    if (r_hit2 && i_osd_en)
    begin
      if (pix_on)
      begin
        o_video.r = 8'hFF;
        o_video.g = 8'hFF;
        o_video.b = 8'hFF;
      end
      else
      begin
        o_video.r = r_v2.r >> 1; // half intensity background
        o_video.g = r_v2.g >> 1;
        o_video.b = r_v2.b >> 1;
      end
    end
  end

endmodule

/* logic/font_rom.sv */
`timescale 1ns/1ps

module font_rom
(
  input  logic       clk_cpu,
  input  logic [3:0] i_glyph,
  input  logic [2:0] i_row,
  output logic [7:0] o_bits
);

  logic [63:0] r_font [0:15]; // one word per glyph
  logic [5:0]  bit_base;

  initial
  begin
    $readmemh("font.mem", r_font);
  end

  // row 0 sits in the top byte
  assign bit_base = {~i_row, 3'b000};

  always_ff @(posedge clk_cpu)
  begin
    o_bits <= r_font[i_glyph][bit_base +: 8];
  end

endmodule

/* logic/video_timing.sv */
`timescale 1ns/1ps
`include "osd_params.svh"

module video_timing
  import osd_pkg::*;
(
  input  logic   clk_cpu,
  input  logic   i_rst_n,
  output video_t o_video
);

  localparam int HS_START = `OSD_H_ACTIVE + `OSD_H_FRONT;
  localparam int HS_END   = HS_START + `OSD_H_SYNC;
  localparam int VS_START = `OSD_V_ACTIVE + `OSD_V_FRONT;
  localparam int VS_END   = VS_START + `OSD_V_SYNC;

  logic [7:0] r_hcnt;
  logic [6:0] r_vcnt;
  logic       active;

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      r_hcnt <= '0;
      r_vcnt <= '0;
    end
    else if (r_hcnt == 8'(`OSD_H_TOTAL - 1))
    begin
      r_hcnt <= '0;
      if (r_vcnt == 7'(`OSD_V_TOTAL - 1))
        r_vcnt <= '0;
      else
        r_vcnt <= r_vcnt + 7'd1;
    end
    else
      r_hcnt <= r_hcnt + 8'd1;
  end

  assign active = (r_hcnt < `OSD_H_ACTIVE) && (r_vcnt < `OSD_V_ACTIVE);

  always_comb
  begin
    o_video.x     = r_hcnt;
    o_video.y     = r_vcnt;
    o_video.hsync = (r_hcnt >= HS_START) && (r_hcnt < HS_END);
    o_video.vsync = (r_vcnt >= VS_START) && (r_vcnt < VS_END);
    o_video.blank = ~active;
    // test picture, black in blanking
    o_video.r     = active ? r_hcnt : 8'd0;
    o_video.g     = active ? {1'b0, r_vcnt} : 8'd0;
    o_video.b     = active ? 8'h80 : 8'd0;
  end

endmodule

/* logic/osd_store.sv */
`timescale 1ns/1ps
`include "osd_params.svh"

module osd_store
  import osd_pkg::*;
(
  input  logic                    clk_cpu,
  input  logic                    i_rst_n,
  input  bus_req_t                i_req,
  input  logic [`OSD_CHAR_AW-1:0] i_char_addr,
  output logic [7:0]              o_rd_data,
  output logic [7:0]              o_char,
  output logic                    o_osd_en
);

  logic [7:0]              r_ram [0:(1 << `OSD_CHAR_AW) - 1];
  logic [`OSD_CHAR_AW-1:0] a_addr;
  region_e                 region;

  assign region = region_e'(i_req.addr[31:24]);
  assign a_addr = i_req.addr[`OSD_CHAR_AW-1:0];

  // port A, cpu side
  always_ff @(posedge clk_cpu)
  begin
    if (i_req.wr && (region == REG_CHAR))
      r_ram[a_addr] <= i_req.wdata;
  end

  always_ff @(posedge clk_cpu)
  begin
    if (i_req.rd)
    begin
      case (region)
        REG_CHAR: o_rd_data <= r_ram[a_addr];
        REG_CTRL: o_rd_data <= {7'd0, o_osd_en};
        default:  o_rd_data <= 8'd0; // btn served by the slave
      endcase
    end
  end

  // port B, overlay fetch
  always_ff @(posedge clk_cpu)
  begin
    o_char <= r_ram[i_char_addr];
  end

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
      o_osd_en <= 1'(`OSD_INIT_ON);
    else if (i_req.wr && (region == REG_CTRL))
      o_osd_en <= i_req.wdata[0];
  end

endmodule

/* logic/spi_ram_slave.sv */
`timescale 1ns/1ps
`include "osd_params.svh"

module spi_ram_slave
  import osd_pkg::*;
(
  input  logic                  clk_cpu,
  input  logic                  i_rst_n,
  input  logic                  i_csn,
  input  logic                  i_sclk,
  input  logic                  i_mosi,
  input  logic [`OSD_BTN_W-1:0] i_btn,
  input  logic [7:0]            i_rd_data,
  output logic                  o_miso,
  output logic                  o_irq,
  output bus_req_t              o_req
);

  logic [1:0]            r_csn_sync;
  logic [2:0]            r_sclk_sync; // bit 2 is the previous synced level
  logic [1:0]            r_mosi_sync;
  spi_state_e            r_state;
  logic [4:0]            r_bit_cnt;
  logic [7:0]            r_shift;
  logic [31:0]           r_addr;
  logic                  r_op_ok;
  logic                  r_op_rd;
  logic                  r_rd_pend;
  logic [7:0]            r_tx;
  logic [7:0]            r_tx_hold;    // next byte for miso
  logic [`OSD_BTN_W-1:0] r_btn_q;
  logic [`OSD_BTN_W-1:0] r_btn_snap;
  logic [`OSD_BTN_W-1:0] r_btn_seen;
  logic                  r_btn_rd;
  logic                  csn_s;
  logic                  mosi_s;
  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  byte_done;
  logic                  frame_end;
  logic                  rd_is_btn;
  logic [7:0]            rx_byte;
  logic [31:0]           addr_next;
  logic [7:0]            btn_byte;
  spi_op_e               op_in;

  assign csn_s     = r_csn_sync[1];
  assign mosi_s    = r_mosi_sync[1];
  assign sclk_rise = r_sclk_sync[1] & ~r_sclk_sync[2];
  assign sclk_fall = ~r_sclk_sync[1] & r_sclk_sync[2];
  assign byte_done = (r_bit_cnt[2:0] == 3'd7);
  assign rx_byte   = {r_shift[6:0], mosi_s};
  assign addr_next = {r_addr[30:0], mosi_s};
  assign op_in     = spi_op_e'(rx_byte);
  assign frame_end = csn_s && (r_state != ST_IDLE);
  assign rd_is_btn = (region_e'(o_req.addr[31:24]) == REG_BTN); // addr held after rd
  assign btn_byte  = {{(8 - `OSD_BTN_W){1'b0}}, r_btn_q};

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      r_csn_sync  <= 2'b11;
      r_sclk_sync <= '0;
      r_mosi_sync <= '0;
    end
    else
    begin
      r_csn_sync  <= {r_csn_sync[0], i_csn};
      r_sclk_sync <= {r_sclk_sync[1:0], i_sclk};
      r_mosi_sync <= {r_mosi_sync[0], i_mosi};
    end
  end

  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      r_state   <= ST_IDLE;
      r_bit_cnt <= '0;
      r_op_ok   <= 1'b0;
      r_op_rd   <= 1'b0;
      r_rd_pend <= 1'b0;
      r_tx      <= '0;
      o_miso    <= 1'b0;
      o_req.wr  <= 1'b0;
      o_req.rd  <= 1'b0;
    end
    else
    begin
      o_req.wr  <= 1'b0;
      o_req.rd  <= 1'b0;
      r_rd_pend <= o_req.rd; // store answers one cycle after rd
      if (csn_s)
      begin
        r_state   <= ST_IDLE;
        r_bit_cnt <= '0;
        r_tx      <= '0;
        o_miso    <= 1'b0;
      end
      else if (r_state == ST_IDLE)
        r_state <= ST_CMD;
      else if (sclk_rise)
      begin
        r_shift   <= rx_byte;
        r_bit_cnt <= r_bit_cnt + 5'd1;
        case (r_state)
          ST_CMD:
            if (byte_done)
            begin
              r_bit_cnt <= '0;
              r_op_rd   <= (op_in == OP_READ);
              r_op_ok   <= (op_in == OP_WRITE) || (op_in == OP_READ);
              // unknown opcode drops into data phase and idles there
              r_state   <= ((op_in == OP_WRITE) || (op_in == OP_READ)) ? ST_ADDR : ST_DATA;
            end
          ST_ADDR:
          begin
            r_addr <= addr_next;
            if (r_bit_cnt == 5'd31)
            begin
              r_bit_cnt <= '0;
              if (r_op_rd)
              begin
                o_req.rd   <= 1'b1; // fetch first byte during dummy
                o_req.addr <= addr_next;
                r_state    <= ST_DUMMY;
              end
              else
                r_state <= ST_DATA;
            end
          end
          ST_DUMMY:
            if (byte_done)
            begin
              r_bit_cnt <= '0;
              r_state   <= ST_DATA;
            end
          default:
            if (byte_done)
            begin
              r_bit_cnt <= '0;
              if (r_op_ok)
              begin
                r_addr <= r_addr + 32'd1;
                if (r_op_rd)
                begin
                  o_req.rd   <= 1'b1; // prefetch next byte
                  o_req.addr <= r_addr + 32'd1;
                end
                else
                begin
                  o_req.wr    <= 1'b1;
                  o_req.addr  <= r_addr;
                  o_req.wdata <= rx_byte;
                end
              end
            end
        endcase
      end
      else if (sclk_fall)
      begin
        if ((r_state == ST_DATA) && r_op_rd && (r_bit_cnt[2:0] == 3'd0))
        begin
          o_miso <= r_tx_hold[7]; // first bit of a fresh byte
          r_tx   <= {r_tx_hold[6:0], 1'b0};
        end
        else
        begin
          o_miso <= r_tx[7];
          r_tx   <= {r_tx[6:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk_cpu)
  begin
    if (r_rd_pend)
      r_tx_hold <= rd_is_btn ? btn_byte : i_rd_data;
  end

  // button register and change interrupt
  always_ff @(posedge clk_cpu)
  begin
    if (!i_rst_n)
    begin
      r_btn_q    <= '0;
      r_btn_snap <= '0;
      r_btn_seen <= '0;
      r_btn_rd   <= 1'b0;
      o_irq      <= 1'b0;
    end
    else
    begin
      r_btn_q <= i_btn;
      o_irq   <= (r_btn_q != r_btn_seen);
      if (r_rd_pend && rd_is_btn)
      begin
        r_btn_snap <= r_btn_q;
        r_btn_rd   <= 1'b1;
      end
      if (frame_end && r_btn_rd)
      begin
        r_btn_seen <= r_btn_snap; // acknowledged once csn rises
        r_btn_rd   <= 1'b0;
      end
    end
  end

endmodule

/* logic/osd_pkg.sv */
package osd_pkg;

  // spi slave frame phases
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_ADDR,
    ST_DUMMY,
    ST_DATA
  } spi_state_e;

  typedef enum logic [7:0] {
    OP_WRITE = 8'h00,
    OP_READ  = 8'h01
  } spi_op_e;

  // top address byte selects the target
  typedef enum logic [7:0] {
    REG_CHAR = 8'h00,
    REG_BTN  = 8'hFB,
    REG_CTRL = 8'hFD
  } region_e;

  typedef struct packed {
    logic        wr;    // single-cycle strobes
    logic        rd;
    logic [31:0] addr;
    logic [7:0]  wdata;
  } bus_req_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    logic       hsync;
    logic       vsync;
    logic       blank;
    logic [7:0] x;      // beam position
    logic [6:0] y;
  } video_t;

endpackage

/* include/osd_params.svh */
`ifndef OSD_PARAMS_SVH
`define OSD_PARAMS_SVH

// video timing in pixels and lines
`define OSD_H_ACTIVE 160
`define OSD_H_FRONT  8
`define OSD_H_SYNC   16
`define OSD_H_BACK   16
`define OSD_H_TOTAL  200
`define OSD_V_ACTIVE 120
`define OSD_V_FRONT  2
`define OSD_V_SYNC   2
`define OSD_V_BACK   4
`define OSD_V_TOTAL  128

// window placement, size in characters
`define OSD_WIN_X    16
`define OSD_WIN_Y    16
`define OSD_CHARS_X  8
`define OSD_CHARS_Y  4
`define OSD_GLYPH_PX 8

`define OSD_CHAR_AW  5 // 32 character bytes
`define OSD_BTN_W    7
`define OSD_INIT_ON  1

`endif
